// ==== all.f ====
src/tftPkg.sv
src/tftCmdRom.sv
src/tftSequencer.sv
src/tftBusWriter.sv
src/tftCtrl.sv
tests/tftBus_props.sv
tests/tftBusChecker.sv
tests/tftCtrlTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tftCtrlTb -f all.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/VtftCtrlTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

// ==== tests/tftCtrlTb.sv ====
`timescale 1ns/1ps

module tftCtrlTb;
    import tftPkg::*;

    // two frames with random stalls need roughly 700k cycles
    localparam int maxCycles = 2000000;
    localparam int maxRestarts = 2;

    logic clk;
    logic reset;
    logic newFrame;
    logic dataReady;
    logic [pixelWidth-1:0] pixelData;
    logic [addrWidth-1:0] pixelAddr;
    logic [busWidth-1:0] tftData;
    logic tftCsN;
    logic tftWrN;
    logic tftResetN;
    logic tftDc;

    int valueErrors;
    int protocolErrors;
    int frameCount;
    int restartCount;

    integer seed = 32'hb811;
    int draw;
    int pulses;
    int cycles;
    logic timedOut;
    logic noRestart;

    // pixel source is a fixed scramble of the address
    function automatic logic [15:0] pixelHash(input logic [15:0] addr);
        return (addr ^ 16'h5A5A) + (addr << 3);
    endfunction

    tftCtrl uut (
        .clk       (clk),
        .reset     (reset),
        .newFrame  (newFrame),
        .dataReady (dataReady),
        .pixelData (pixelData),
        .pixelAddr (pixelAddr),
        .tftData   (tftData),
        .tftCsN    (tftCsN),
        .tftWrN    (tftWrN),
        .tftResetN (tftResetN),
        .tftDc     (tftDc)
    );

    tftBusChecker busChecker (
        .clk            (clk),
        .reset          (reset),
        .newFrame       (newFrame),
        .pixelAddr      (pixelAddr),
        .tftData        (tftData),
        .tftCsN         (tftCsN),
        .tftWrN         (tftWrN),
        .tftResetN      (tftResetN),
        .tftDc          (tftDc),
        .valueErrors    (valueErrors),
        .protocolErrors (protocolErrors),
        .frameCount     (frameCount),
        .restartCount   (restartCount)
    );

    initial
    begin
        clk = 1'b0;
    end

    // 20 ns period
    always #10 clk = ~clk;

    // inputs change 2 ns after each rising edge
    initial
    begin
        newFrame = 1'b0;
        dataReady = 1'b0;
        pixelData = '0;
        pulses = 0;
        forever
        begin
            @(posedge clk);
            #2;
            // ready about three cycles out of four
            draw = $random(seed);
            dataReady = (draw & 3) != 0;
            // rare restarts only while the second frame streams
            draw = $random(seed);
            if (!reset && frameCount == 1 && pulses < maxRestarts && (draw & 32'hfff) == 0)
            begin
                newFrame = 1'b1;
                pulses++;
            end
            else
                newFrame = 1'b0;
            pixelData = pixelHash(pixelAddr[15:0]);
        end
    end

    initial
    begin
        reset = 1'b1;
        cycles = 0;
        timedOut = 1'b0;
        noRestart = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        // run until the checker has seen two complete frames
        while (frameCount < 2 && !timedOut)
        begin
            @(posedge clk);
            cycles++;
            if (cycles >= maxCycles)
                timedOut = 1'b1;
        end

        if (timedOut)
            $display("timeout: two frames did not finish within %0d cycles", maxCycles);
        else if (restartCount == 0)
        begin
            noRestart = 1'b1;
            $display("no frame restart happened during the second frame");
        end
        $display("errors: value %0d, protocol %0d (frames %0d, restarts %0d)",
                 valueErrors, protocolErrors, frameCount, restartCount);
        if (timedOut || noRestart || valueErrors != 0 || protocolErrors != 0)
            $display("Simulation failed");
        else
            $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== tests/tftBusChecker.sv ====
`timescale 1ns/1ps

module tftBusChecker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         newFrame,
    input  logic [tftPkg::addrWidth-1:0] pixelAddr,
    input  logic [tftPkg::busWidth-1:0]  tftData,
    input  logic                         tftCsN,
    input  logic                         tftWrN,
    input  logic                         tftResetN,
    input  logic                         tftDc,
    output int                           valueErrors,
    output int                           protocolErrors,
    output int                           frameCount,
    output int                           restartCount
);
    import tftPkg::*;

    // sync bytes, init table and display-on
    localparam int bootLength = syncLength + initLength + 1;
    localparam int stallLimit = 2000;
    localparam int printLimit = 20;

    typedef enum logic [1:0] {
        modelBoot,
        modelWindow,
        modelPixels
    } modelState;

    modelState state;
    int tableIndex;
    int pixelIndex;
    // next pixel byte is the high one
    logic highNext;
    // restart seen by the model, taken at the next word boundary
    logic pending;
    logic resetSeen;
    int resetLowCount;
    int stallCount;
    logic [busWidth:0] actual;
    logic [15:0] expWord;

    function automatic logic [15:0] pixelHash(input logic [15:0] addr);
        return (addr ^ 16'h5A5A) + (addr << 3);
    endfunction

    // expected entry of the boot stream by position
    function automatic logic [busWidth:0] bootEntry(input int idx);
        if (idx < syncLength)
            return {1'b0, 8'h00};
        else if (idx < syncLength + initLength)
            return initTable[idx - syncLength];
        else
            return {1'b0, displayOnCmd};
    endfunction

    task automatic checkByte(input string testName, input logic [busWidth:0] exp,
                             input logic [busWidth:0] act, input int idx);
        if (act !== exp)
        begin
            valueErrors++;
            if (valueErrors <= printLimit)
                $display("ERR %s expected %h actual %h at word %0d", testName, exp, act, idx);
        end
    endtask

    // pixel address must name the word on the bus
    task automatic checkAddr(input int exp, input logic [addrWidth-1:0] act);
        if (act !== addrWidth'(exp))
        begin
            valueErrors++;
            if (valueErrors <= printLimit)
                $display("ERR address expected %0d actual %0d", exp, act);
        end
    endtask

    // sampled on the falling clock edge away from the DUT's updates
    // a low strobe here means the byte is taken on the next rising edge
    always @(negedge clk or posedge reset)
    begin
        if (reset)
        begin
            state = modelBoot;
            tableIndex = 0;
            pixelIndex = 0;
            highNext = 1'b1;
            pending = 1'b0;
            resetSeen = 1'b0;
            resetLowCount = 0;
            stallCount = 0;
            valueErrors = 0;
            protocolErrors = 0;
            frameCount = 0;
            restartCount = 0;
        end
        else
        begin
            // width of the panel reset pulse
            if (!resetSeen)
            begin
                if (!tftResetN)
                    resetLowCount++;
                else if (resetLowCount > 0)
                begin
                    resetSeen = 1'b1;
                    if (resetLowCount < resetLowCycles - 1
                        || resetLowCount > resetLowCycles + 1)
                    begin
                        protocolErrors++;
                        $display("ERR reset expected %0d actual %0d",
                                 resetLowCycles, resetLowCount);
                    end
                end
            end

            if (!tftWrN)
            begin
                stallCount = 0;
                if (!resetSeen)
                begin
                    protocolErrors++;
                    $display("write strobe seen before the panel reset pulse ended");
                end
                if (tftCsN)
                begin
                    protocolErrors++;
                    $display("write strobe seen while chip select was high");
                end
                actual = {tftDc, tftData};
                case (state)
                    modelBoot:
                    begin
                        checkByte("command", bootEntry(tableIndex), actual, tableIndex);
                        tableIndex++;
                        if (tableIndex == bootLength)
                        begin
                            state = modelWindow;
                            tableIndex = 0;
                        end
                    end
                    modelWindow:
                    begin
                        checkByte("window", windowTable[tableIndex], actual, tableIndex);
                        tableIndex++;
                        if (tableIndex == windowLength)
                        begin
                            state = modelPixels;
                            pixelIndex = 0;
                            highNext = 1'b1;
                            pending = 1'b0;
                        end
                    end
                    default:
                    begin
                        expWord = pixelHash(pixelIndex[15:0]);
                        checkAddr(pixelIndex, pixelAddr);
                        if (highNext)
                        begin
                            checkByte("pixel", {1'b1, expWord[15:8]}, actual, pixelIndex);
                            highNext = 1'b0;
                            pending = pending | newFrame;
                        end
                        else
                        begin
                            checkByte("pixel", {1'b1, expWord[7:0]}, actual, pixelIndex);
                            highNext = 1'b1;
                            // at a word boundary the end of frame or a restart goes back
                            if (pixelIndex == framePixels - 1)
                            begin
                                frameCount++;
                                state = modelWindow;
                                tableIndex = 0;
                                pending = 1'b0;
                            end
                            else if (pending)
                            begin
                                restartCount++;
                                state = modelWindow;
                                tableIndex = 0;
                                pending = 1'b0;
                            end
                            else
                            begin
                                // a pulse on the boundary waits one more word
                                pending = pending | newFrame;
                                pixelIndex++;
                            end
                        end
                    end
                endcase
            end
            else
            begin
                if (state == modelPixels)
                    pending = pending | newFrame;
                if (resetSeen)
                begin
                    stallCount++;
                    if (stallCount == stallLimit)
                    begin
                        protocolErrors++;
                        $display("bus stalled with no write strobe for %0d cycles", stallLimit);
                    end
                end
            end
        end
    end

endmodule

// ==== tests/tftBus_props.sv ====
`timescale 1ns/1ps

module tftBusProps (
    input logic                        clk,
    input logic                        reset,
    input tftPkg::ctrlPhase            phase,
    input logic [tftPkg::busWidth-1:0] tftData,
    input logic                        tftWrN,
    input logic                        tftDc,
    input logic                        dataReady,
    input logic                        lowByte
);
    import tftPkg::*;

    // one low cycle per byte
    strobeWidth: assert property (@(posedge clk) disable iff (reset) !tftWrN |=> tftWrN)
        else $error("write strobe low for more than one cycle");

    // byte and flag hold through the rising edge
    dataStable: assert property (@(posedge clk) disable iff (reset)
        !tftWrN |=> ($stable(tftData) && $stable(tftDc)))
        else $error("bus byte changed while the strobe was low");

    // panel reset phases keep the bus quiet
    quietInReset: assert property (@(posedge clk) disable iff (reset)
        (phase == RESET_LOW || phase == RESET_HOLD) |-> tftWrN)
        else $error("write strobe during panel reset");

    // a pixel word does not start without dataReady
    pixelGate: assert property (@(posedge clk) disable iff (reset)
        (phase == PIXELS && tftWrN && !lowByte && !dataReady) |=> tftWrN)
        else $error("pixel word started while dataReady was low");

endmodule

bind tftBusWriter tftBusProps busProps (
    .clk       (clk),
    .reset     (reset),
    .phase     (phase),
    .tftData   (tftData),
    .tftWrN    (tftWrN),
    .tftDc     (tftDc),
    .dataReady (dataReady),
    .lowByte   (lowByte)
);

// ==== src/tftCtrl.sv ====
`timescale 1ns/1ps

module tftCtrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          newFrame,
    input  logic                          dataReady,
    input  logic [tftPkg::pixelWidth-1:0] pixelData,
    output logic [tftPkg::addrWidth-1:0]  pixelAddr,
    output logic [tftPkg::busWidth-1:0]   tftData,
    output logic                          tftCsN,
    output logic                          tftWrN,
    output logic                          tftResetN,
    output logic                          tftDc
);
    import tftPkg::*;

    // phase shared by all three blocks
    ctrlPhase phase;
    // byte and data flag for the current command word
    romEntry entry;
    // writer tells the sequencer a word is on the bus
    logic wordDone;

    // word index goes straight out as the pixel address
    tftSequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .newFrame  (newFrame),
        .wordDone  (wordDone),
        .phase     (phase),
        .wordIndex (pixelAddr),
        .tftCsN    (tftCsN),
        .tftResetN (tftResetN)
    );

    tftCmdRom cmdRom (
        .phase     (phase),
        .wordIndex (pixelAddr),
        .entry     (entry)
    );

    tftBusWriter busWriter (
        .clk       (clk),
        .reset     (reset),
        .phase     (phase),
        .entry     (entry),
        .pixelData (pixelData),
        .dataReady (dataReady),
        .tftData   (tftData),
        .tftWrN    (tftWrN),
        .tftDc     (tftDc),
        .wordDone  (wordDone)
    );

endmodule

// ==== src/tftBusWriter.sv ====
`timescale 1ns/1ps

module tftBusWriter (
    input  logic                          clk,
    input  logic                          reset,
    input  tftPkg::ctrlPhase              phase,
    input  tftPkg::romEntry               entry,
    input  logic [tftPkg::pixelWidth-1:0] pixelData,
    input  logic                          dataReady,
    output logic [tftPkg::busWidth-1:0]   tftData,
    output logic                          tftWrN,
    output logic                          tftDc,
    output logic                          wordDone
);
    import tftPkg::*;

    logic writing;
    logic pixelPhase;
    // set while the low byte of a pixel is the next one out
    logic lowByte;
    logic startByte;
    logic [busWidth-1:0] nextByte;

    always_comb
    begin
        case (phase)
            SYNC, INIT, DISPLAY_ON, WINDOW, PIXELS: writing = 1'b1;
            default: writing = 1'b0;
        endcase
    end

    assign pixelPhase = (phase == PIXELS);

    // a byte starts only with the strobe high, so each byte is low then high
    // pixel words wait for dataReady, the low byte of a started word never does
    assign startByte = tftWrN && writing && (!pixelPhase || lowByte || dataReady);

    // high byte of the pixel goes first
    always_comb
    begin
        if (!pixelPhase)
            nextByte = entry[busWidth-1:0];
        else if (lowByte)
            nextByte = pixelData[busWidth-1:0];
        else
            nextByte = pixelData[pixelWidth-1:busWidth];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            tftWrN <= 1'b1;
            tftDc <= 1'b0;
            wordDone <= 1'b0;
            lowByte <= 1'b0;
        end
        else
        begin
            // strobe low for one cycle per byte, the panel latches on the rise
            tftWrN <= !startByte;

            // wordDone rides the low cycle of the last byte in a word
            // so the next entry is ready when the strobe returns high
            wordDone <= startByte && (!pixelPhase || lowByte);

            if (startByte)
                tftDc <= pixelPhase ? 1'b1 : entry[busWidth];

            // byte pairing restarts outside the pixel stream
            if (!pixelPhase)
                lowByte <= 1'b0;
            else if (startByte)
                lowByte <= !lowByte;
        end
    end

    // bus byte held until the next strobe
    always_ff @(posedge clk)
    begin
        if (startByte)
            tftData <= nextByte;
    end

endmodule

// ==== src/tftSequencer.sv ====
`timescale 1ns/1ps

module tftSequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         newFrame,
    input  logic                         wordDone,
    output tftPkg::ctrlPhase             phase,
    output logic [tftPkg::addrWidth-1:0] wordIndex,
    output logic                         tftCsN,
    output logic                         tftResetN
);
    import tftPkg::*;

    ctrlPhase phaseNext;
    logic [delayWidth-1:0] delayCount;
    logic delayDone;
    logic lastWord;
    // newFrame seen during PIXELS, acted on at a later word boundary
    logic framePending;

    // load value for a delay phase, phase lasts load plus one cycles
    function automatic logic [delayWidth-1:0] delayLoad(input ctrlPhase p);
        logic [delayWidth-1:0] load;
        case (p)
            RESET_LOW:  load = delayWidth'(resetLowCycles - 1);
            RESET_HOLD: load = delayWidth'(resetHoldCycles - 1);
            SYNC_DELAY: load = delayWidth'(syncDelayCycles - 1);
            INIT_DELAY: load = delayWidth'(initDelayCycles - 1);
            ON_DELAY:   load = delayWidth'(onDelayCycles - 1);
            default:    load = '0;
        endcase
        return load;
    endfunction

    // index of the last word in each writing phase
    function automatic logic [addrWidth-1:0] lastIndex(input ctrlPhase p);
        logic [addrWidth-1:0] idx;
        case (p)
            SYNC:    idx = addrWidth'(syncLength - 1);
            INIT:    idx = addrWidth'(initLength - 1);
            WINDOW:  idx = addrWidth'(windowLength - 1);
            PIXELS:  idx = addrWidth'(framePixels - 1);
            default: idx = '0;
        endcase
        return idx;
    endfunction

    assign delayDone = (delayCount == '0);
    assign lastWord = (wordIndex == lastIndex(phase));

    always_comb
    begin
        phaseNext = phase;
        case (phase)
            RESET_LOW:  if (delayDone) phaseNext = RESET_HOLD;
            RESET_HOLD: if (delayDone) phaseNext = SYNC;
            SYNC:       if (wordDone && lastWord) phaseNext = SYNC_DELAY;
            SYNC_DELAY: if (delayDone) phaseNext = INIT;
            INIT:       if (wordDone && lastWord) phaseNext = INIT_DELAY;
            INIT_DELAY: if (delayDone) phaseNext = DISPLAY_ON;
            DISPLAY_ON: if (wordDone) phaseNext = ON_DELAY;
            ON_DELAY:   if (delayDone) phaseNext = WINDOW;
            WINDOW:     if (wordDone && lastWord) phaseNext = PIXELS;
            // end of frame or a pending restart both go back to the window
            PIXELS:     if (wordDone && (lastWord || framePending)) phaseNext = WINDOW;
            default:    phaseNext = RESET_LOW;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase <= RESET_LOW;
            delayCount <= delayLoad(RESET_LOW);
            wordIndex <= '0;
            framePending <= 1'b0;
            // panel reset only drops on the first edge out of reset
            tftResetN <= 1'b1;
            tftCsN <= 1'b1;
        end
        else
        begin
            phase <= phaseNext;

            // reload on each phase change, otherwise count down to zero
            if (phaseNext != phase)
                delayCount <= delayLoad(phaseNext);
            else if (!delayDone)
                delayCount <= delayCount - 1'b1;

            // index restarts with every phase, steps once per word
            if (phaseNext != phase)
                wordIndex <= '0;
            else if (wordDone)
                wordIndex <= wordIndex + 1'b1;

            // a pulse landing on a word boundary waits for the next one
            if (phase == PIXELS && phaseNext == PIXELS)
                framePending <= framePending | newFrame;
            else
                framePending <= 1'b0;

            tftResetN <= (phaseNext != RESET_LOW);

            // chip select stays low from display-on through the stream
            case (phaseNext)
                SYNC, INIT, DISPLAY_ON, ON_DELAY, WINDOW, PIXELS: tftCsN <= 1'b0;
                default: tftCsN <= 1'b1;
            endcase
        end
    end

endmodule

// ==== src/tftCmdRom.sv ====
`timescale 1ns/1ps

module tftCmdRom (
    input  tftPkg::ctrlPhase             phase,
    input  logic [tftPkg::addrWidth-1:0] wordIndex,
    output tftPkg::romEntry              entry
);
    import tftPkg::*;

    // the command tables are short, low index bits are enough
    logic [tableIndexWidth-1:0] tableIndex;
    logic initInRange;
    logic windowInRange;

    assign tableIndex = wordIndex[tableIndexWidth-1:0];
    assign initInRange = (wordIndex < addrWidth'(initLength));
    assign windowInRange = (wordIndex < addrWidth'(windowLength));

    always_comb
    begin
        case (phase)
            // sync bytes are plain nop commands
            SYNC:
            begin
                entry = {1'b0, 8'h00};
            end
            INIT:
            begin
                if (initInRange)
                    entry = initTable[tableIndex];
                else
                    entry = '0;
            end
            DISPLAY_ON:
            begin
                entry = {1'b0, displayOnCmd};
            end
            WINDOW:
            begin
                if (windowInRange)
                    entry = windowTable[tableIndex];
                else
                    entry = '0;
            end
            // delays and pixels take nothing from the tables
            default:
            begin
                entry = '0;
            end
        endcase
    end

endmodule

// ==== src/tftPkg.sv ====
package tftPkg;

    // panel bus and pixel format
    localparam int busWidth = 8;
    localparam int pixelWidth = 16;

    // word index doubles as the pixel address
    localparam int addrWidth = 17;

    // panel geometry in landscape
    localparam int frameWidth = 320;
    localparam int frameHeight = 240;
    localparam int framePixels = frameWidth * frameHeight;

    // delay counter and table index widths
    localparam int delayWidth = 16;
    localparam int tableIndexWidth = 4;

    // top bit set marks a data byte, clear marks a command byte
    typedef logic [busWidth:0] romEntry;

    // word counts of the table phases
    localparam int syncLength = 3;
    localparam int initLength = 12;
    localparam int windowLength = 11;

    localparam logic [busWidth-1:0] displayOnCmd = 8'h29;

    // short power-up sequence, each command followed by its data bytes
    localparam romEntry initTable [initLength] = '{
        // power control 1
        9'h0C0,
        9'h123,
        // power control 2
        9'h0C1,
        9'h110,
        // vcom control, two parameters
        9'h0C5,
        9'h13E,
        9'h128,
        // memory access control, bgr order
        9'h036,
        9'h148,
        // pixel format, 16 bits per pixel
        9'h03A,
        9'h155,
        // sleep out
        9'h011
    };

    // window setup sent before every frame
    localparam romEntry windowTable [windowLength] = '{
        // column range 0 to 319
        9'h02A,
        9'h100,
        9'h100,
        9'h101,
        9'h13F,
        // page range 0 to 239
        9'h02B,
        9'h100,
        9'h100,
        9'h100,
        9'h1EF,
        // memory write opens the pixel stream
        9'h02C
    };

    // delays in clk cycles, shortened for simulation
    // a 50 MHz board build scales these to milliseconds
    localparam int resetLowCycles = 40;
    localparam int resetHoldCycles = 120;
    localparam int syncDelayCycles = 20;
    localparam int initDelayCycles = 120;
    localparam int onDelayCycles = 120;

    // controller phases in the order they run
    typedef enum logic [3:0] {
        RESET_LOW,
        RESET_HOLD,
        SYNC,
        SYNC_DELAY,
        INIT,
        INIT_DELAY,
        DISPLAY_ON,
        ON_DELAY,
        WINDOW,
        PIXELS
    } ctrlPhase;

endpackage
